/* list.f */
verilog/e40_fmt_pkg.sv
verilog/e40_am_pkg.sv
verilog/e40_traffic_break.sv
verilog/e40_am_sched.sv
verilog/e40_am_insert.sv
verilog/e40_frame_mon.sv
verilog/e40_tx_gap_top.sv
bench/e40_tx_gap_tb.sv

/* Bender.yml */
package:
  name: e40_tx_gap

sources:
  - files:
      - verilog/e40_fmt_pkg.sv
      - verilog/e40_am_pkg.sv
      - verilog/e40_traffic_break.sv
      - verilog/e40_am_sched.sv
      - verilog/e40_am_insert.sv
      - verilog/e40_frame_mon.sv
      - verilog/e40_tx_gap_top.sv
  - target: simulation
    files:
      - bench/e40_tx_gap_tb.sv

/* bench/e40_tx_gap_tb.sv */
// runs with WORDS = 2 and a 20-cycle marker period; each packet starts on word 0 and spans two cycles or more
module e40_tx_gap_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS     = 2;
	localparam int AM_PERIOD = 20;
	localparam int N_ROWS    = 16;

	logic                              clk;
	logic                              arst;
	e40_fmt_pkg::word_t    [WORDS-1:0] din;
	logic                  [WORDS-1:0] din_start;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] din_end_pos;
	logic                              din_ack;
	logic                              dout_ack;
	e40_fmt_pkg::word_t    [WORDS-1:0] dout;
	logic                  [WORDS-1:0] dout_start;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] dout_end_pos;
	logic                  [WORDS-1:0] dout_marker;
	e40_am_pkg::am_count_t             pkt_count;
	logic                              frame_err;

	// packet table with one column per field for length in words, closing byte and ack pattern
	// pattern 0 is always ready, 1 every other cycle, 2 three cycles in four, 3 random
	int tab_len  [N_ROWS] = '{3, 5, 8, 3, 9, 4, 4, 7, 6, 3, 9, 5, 4, 8, 6, 3};
	int tab_last [N_ROWS] = '{7, 0, 3, 5, 1, 6, 0, 4, 2, 7, 5, 3, 1, 6, 0, 2};
	int tab_ack  [N_ROWS] = '{0, 0, 1, 0, 2, 3, 1, 0, 2, 3, 0, 1, 0, 2, 3, 0};

	// bus cycles built from the table, with a per-word flag for real packet words
	e40_fmt_pkg::word_t    [WORDS-1:0] src_data [$];
	logic                  [WORDS-1:0] src_start [$];
	e40_fmt_pkg::end_pos_t [WORDS-1:0] src_end [$];
	logic                  [WORDS-1:0] src_valid [$];
	int                                src_ack [$];

	// accepted packet words still owed by the output, oldest first
	e40_fmt_pkg::word_t    exp_data [$];
	logic                  exp_start [$];
	e40_fmt_pkg::end_pos_t exp_end [$];

	// outputs after the last accepted edge, which must hold under back-pressure
	e40_fmt_pkg::word_t    [WORDS-1:0] held_data;
	logic                  [WORDS-1:0] held_start;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] held_end;
	logic                  [WORDS-1:0] held_marker;
	e40_am_pkg::am_count_t             held_count;
	logic                              held_err;

	int   n_mismatch   = 0;
	int   n_other      = 0;
	int   src_idx      = 0;
	int   tb_cycle     = 0;
	int   longest      = 0;
	int   marker_limit = 0;
	int   gap_run      = 0;
	int   n_gaps       = 0;
	int   since_marker = 0;
	logic in_acc       = 1'b0;
	logic out_acc      = 1'b0;
	logic driving_src  = 1'b0;
	logic out_open     = 1'b0;

	e40_tx_gap_top #(
		.WORDS     (WORDS),
		.AM_PERIOD (AM_PERIOD)
	) u_e40_tx_gap_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		n_mismatch++;
		$display("Mismatch %s: got %0h, expected %0h (cycle %0d)", name, got, exp, tb_cycle);
	endtask

	task automatic report_error(input string what);
		n_other++;
		$display("cycle %0d: %s", tb_cycle, what);
	endtask

	// splits every packet into bus cycles; an odd length leaves the last word idle
	task automatic build_stimulus();
		int n_cyc;
		int wi;
		e40_fmt_pkg::word_t    [WORDS-1:0] data;
		logic                  [WORDS-1:0] start;
		e40_fmt_pkg::end_pos_t [WORDS-1:0] end_pos;
		logic                  [WORDS-1:0] valid;
		for (int r = 0; r < N_ROWS; r++) begin
			n_cyc = (tab_len[r] + WORDS - 1) / WORDS;
			longest = (n_cyc > longest) ? n_cyc : longest;
			for (int c = 0; c < n_cyc; c++) begin
				for (int i = 0; i < WORDS; i++) begin
					wi         = c * WORDS + i;
					valid[i]   = wi < tab_len[r];
					data[i]    = valid[i] ? {$urandom(), $urandom()} : '0;
					start[i]   = wi == 0;
					end_pos[i] = '0;
					if (wi == tab_len[r] - 1)
						end_pos[i][tab_last[r]] = 1'b1;
				end
				src_data.push_back(data);
				src_start.push_back(start);
				src_end.push_back(end_pos);
				src_valid.push_back(valid);
				src_ack.push_back(tab_ack[r]);
			end
		end
	endtask

	function automatic logic ack_for_pattern(input int code, input int cyc);
		case (code)
			1: return cyc % 2 == 0;
			2: return cyc % 4 != 3;
			3: return $urandom() % 4 != 0;
			default: return 1'b1;
		endcase
	endfunction

	// drives the current source cycle, held until taken, then looks at the acks for the next edge
	task automatic drive_and_sample();
		driving_src = src_idx < src_data.size();
		if (driving_src) begin
			din         = src_data[src_idx];
			din_start   = src_start[src_idx];
			din_end_pos = src_end[src_idx];
			dout_ack    = ack_for_pattern(src_ack[src_idx], tb_cycle);
		end else begin
			din         = '0;
			din_start   = '0;
			din_end_pos = '0;
			dout_ack    = 1'b1;
		end
		#1;
		in_acc  = din_ack;
		out_acc = dout_ack;
		if (!dout_ack && din_ack !== 1'b0)
			report_error("din_ack is high while dout_ack is low");
	endtask

	// one new output cycle; words inside a packet are popped in order, marker words are rebuilt
	task automatic check_output_cycle();
		e40_fmt_pkg::word_t    e_data;
		logic                  e_start;
		e40_fmt_pkg::end_pos_t e_end;
		for (int i = 0; i < WORDS; i++) begin
			if (dout_marker[i]) begin
				e_data      = e40_am_pkg::AM_PATTERN;
				e_data[7:0] = i[7:0];
				if (dout[i] !== e_data)
					report_mismatch($sformatf("dout[%0d]", i), dout[i], e_data);
				if (dout_start[i] !== 1'b0)
					report_mismatch($sformatf("dout_start[%0d]", i), dout_start[i], 0);
				if (dout_end_pos[i] !== '0)
					report_mismatch($sformatf("dout_end_pos[%0d]", i), dout_end_pos[i], 0);
				if (out_open)
					report_error($sformatf("marker word %0d falls inside a packet", i));
			end else if (dout_start[i] || out_open) begin
				if (dout_start[i] && out_open)
					report_error("a start arrived before the previous packet ended");
				out_open = 1'b1;
				if (exp_data.size() == 0) begin
					report_error($sformatf("packet word %0d on the output with nothing expected", i));
				end else begin
					e_data  = exp_data.pop_front();
					e_start = exp_start.pop_front();
					e_end   = exp_end.pop_front();
					if (dout[i] !== e_data)
						report_mismatch($sformatf("dout[%0d]", i), dout[i], e_data);
					if (dout_start[i] !== e_start)
						report_mismatch($sformatf("dout_start[%0d]", i), dout_start[i], e_start);
					if (dout_end_pos[i] !== e_end)
						report_mismatch($sformatf("dout_end_pos[%0d]", i), dout_end_pos[i], e_end);
				end
				if (|dout_end_pos[i])
					out_open = 1'b0;
			end else if (dout_end_pos[i] !== '0) begin
				report_error($sformatf("end flag on word %0d outside a packet", i));
			end
		end
		// a gap marks whole cycles, and its length is counted in accepted cycles
		if (dout_marker != '0 && dout_marker != '1)
			report_error("only some words of the cycle are markers");
		if (dout_marker[0]) begin
			n_gaps       = (gap_run == 0) ? n_gaps + 1 : n_gaps;
			gap_run      = gap_run + 1;
			since_marker = 0;
		end else begin
			if (gap_run != 0 && gap_run < e40_am_pkg::AM_GAP_CYCLES)
				report_error($sformatf("gap of %0d cycles is below the minimum", gap_run));
			gap_run      = 0;
			since_marker = since_marker + 1;
			if (since_marker == marker_limit + 1)
				report_error($sformatf("no marker within %0d accepted cycles", marker_limit));
		end
	endtask

	task automatic check_held();
		if (dout !== held_data)
			report_mismatch("dout (held)", dout, held_data);
		if (dout_start !== held_start)
			report_mismatch("dout_start (held)", dout_start, held_start);
		if (dout_end_pos !== held_end)
			report_mismatch("dout_end_pos (held)", dout_end_pos, held_end);
		if (dout_marker !== held_marker)
			report_mismatch("dout_marker (held)", dout_marker, held_marker);
		if (pkt_count !== held_count)
			report_mismatch("pkt_count (held)", pkt_count, held_count);
		if (frame_err !== held_err)
			report_mismatch("frame_err (held)", frame_err, held_err);
	endtask

	task automatic save_outputs();
		held_data   = dout;
		held_start  = dout_start;
		held_end    = dout_end_pos;
		held_marker = dout_marker;
		held_count  = pkt_count;
		held_err    = frame_err;
	endtask

	// one bus cycle judges what the last edge produced, records what it took and drives the next
	task automatic run_cycle();
		@(negedge clk);
		tb_cycle++;
		if (out_acc)
			check_output_cycle();
		else
			check_held();
		save_outputs();
		if (in_acc && driving_src) begin
			for (int i = 0; i < WORDS; i++) begin
				if (src_valid[src_idx][i]) begin
					exp_data.push_back(src_data[src_idx][i]);
					exp_start.push_back(src_start[src_idx][i]);
					exp_end.push_back(src_end[src_idx][i]);
				end
			end
			src_idx++;
		end
		drive_and_sample();
	endtask

	initial begin
		arst        = 1'b1;
		din         = '0;
		din_start   = '0;
		din_end_pos = '0;
		dout_ack    = 1'b1;
		void'($urandom(32'h755e));
		build_stimulus();
		// a marker request may have to wait for the longest packet to pass, plus the pipe
		marker_limit = AM_PERIOD + longest + 4;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;
		if (dout_start !== '0)
			report_mismatch("dout_start after reset", dout_start, 0);
		if (dout_marker !== '0)
			report_mismatch("dout_marker after reset", dout_marker, 0);
		if (dout_end_pos !== '0)
			report_mismatch("dout_end_pos after reset", dout_end_pos, 0);
		if (frame_err !== 1'b0)
			report_mismatch("frame_err after reset", frame_err, 0);
		if (pkt_count !== '0)
			report_mismatch("pkt_count after reset", pkt_count, 0);
		save_outputs();
		drive_and_sample();
		while (src_idx < src_data.size() || exp_data.size() != 0)
			run_cycle();
		// the packet counter trails the last end by one accepted edge
		repeat (8)
			run_cycle();
		if (pkt_count !== e40_am_pkg::am_count_t'(N_ROWS))
			report_mismatch("pkt_count", pkt_count, N_ROWS);
		if (frame_err !== 1'b0)
			report_mismatch("frame_err", frame_err, 0);
		if (n_gaps == 0)
			report_error("no marker gap appeared during the run");
		$display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
		if (n_mismatch + n_other == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// limit from the table with two cycles per word, eight gap cycles per period and a margin
	initial begin
		int words;
		int limit;
		int cycles;
		words  = 0;
		cycles = 0;
		for (int r = 0; r < N_ROWS; r++)
			words += tab_len[r];
		limit = 2 * words + 8 * (words / AM_PERIOD + 1) + 100;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* verilog/e40_tx_gap_top.sv */
// din to dout is four accepted edges plus gap cycles; din is held by the source until din_ack
module e40_tx_gap_top #(
	parameter int WORDS     = 2,
	parameter int AM_PERIOD = 64
) (
	input  logic                                 clk,
	input  logic                                 arst,
	input  e40_fmt_pkg::word_t    [WORDS-1:0]    din,
	input  logic                  [WORDS-1:0]    din_start,
	input  e40_fmt_pkg::end_pos_t [WORDS-1:0]    din_end_pos,
	output logic                                 din_ack,
	input  logic                                 dout_ack,
	output e40_fmt_pkg::word_t    [WORDS-1:0]    dout,
	output logic                  [WORDS-1:0]    dout_start,
	output e40_fmt_pkg::end_pos_t [WORDS-1:0]    dout_end_pos,
	output logic                  [WORDS-1:0]    dout_marker,
	output e40_am_pkg::am_count_t                pkt_count,
	output logic                                 frame_err
);

	// break to inserter
	e40_fmt_pkg::word_t    [WORDS-1:0] brk_data;
	logic                  [WORDS-1:0] brk_start;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] brk_end_pos;
	logic                              brk_gap;

	// scheduler handshake with the break
	logic stall_req;
	logic stalled;

	e40_traffic_break #(
		.WORDS (WORDS)
	) u_e40_traffic_break (
		.clk          (clk),
		.arst         (arst),
		.din          (din),
		.din_start    (din_start),
		.din_end_pos  (din_end_pos),
		.din_ack      (din_ack),
		.stall_req    (stall_req),
		.dout         (brk_data),
		.dout_start   (brk_start),
		.dout_end_pos (brk_end_pos),
		.dout_gap     (brk_gap),
		.dout_ack     (dout_ack),
		.stalled      (stalled)
	);

	e40_am_sched #(
		.WORDS     (WORDS),
		.AM_PERIOD (AM_PERIOD)
	) u_e40_am_sched (
		.clk       (clk),
		.arst      (arst),
		.dout_ack  (dout_ack),
		.dout_gap  (brk_gap),
		.stall_req (stall_req)
	);

	e40_am_insert #(
		.WORDS (WORDS)
	) u_e40_am_insert (
		.clk          (clk),
		.arst         (arst),
		.din          (brk_data),
		.din_start    (brk_start),
		.din_end_pos  (brk_end_pos),
		.din_gap      (brk_gap),
		.dout_ack     (dout_ack),
		.dout         (dout),
		.dout_start   (dout_start),
		.dout_end_pos (dout_end_pos),
		.dout_marker  (dout_marker)
	);

	// watches the final output, markers included
	e40_frame_mon #(
		.WORDS (WORDS)
	) u_e40_frame_mon (
		.clk         (clk),
		.arst        (arst),
		.din_start   (dout_start),
		.din_end_pos (dout_end_pos),
		.din_marker  (dout_marker),
		.dout_ack    (dout_ack),
		.pkt_count   (pkt_count),
		.frame_err   (frame_err)
	);

	// an accepted stall cycle in the break turns into markers two accepted edges later
	a_stall_makes_marker: assert property (@(posedge clk) disable iff (arst)
		(stalled && dout_ack) ##1 dout_ack |=> dout_marker[0]);

endmodule

/* verilog/e40_frame_mon.sv */
// counts only accepted cycles; pkt_count wraps at the counter width and frame_err holds until reset
module e40_frame_mon #(
	parameter int WORDS = 2
) (
	input  logic                                 clk,
	input  logic                                 arst,
	input  logic                  [WORDS-1:0]    din_start,
	input  e40_fmt_pkg::end_pos_t [WORDS-1:0]    din_end_pos,
	input  logic                  [WORDS-1:0]    din_marker,
	input  logic                                 dout_ack,
	output e40_am_pkg::am_count_t                pkt_count,
	output logic                                 frame_err
);

	// frame state after the last accepted cycle
	logic frame_open;

	// values after walking the current cycle
	logic                  open_nxt;
	logic                  err_nxt;
	e40_am_pkg::am_count_t pkt_add;

	// words are checked in index order, word 0 being the earliest on the wire
	always_comb begin
		open_nxt = frame_open;
		err_nxt  = 1'b0;
		pkt_add  = '0;
		for (int i = 0; i < WORDS; i++) begin
			// a marker inside a frame means the gap cut a packet
			if (din_marker[i] && open_nxt) begin
				err_nxt = 1'b1;
			end
			// start while open, the previous packet never ended
			if (din_start[i]) begin
				if (open_nxt) begin
					err_nxt = 1'b1;
				end
				open_nxt = 1'b1;
			end
			// a word may hold both start and end for a short packet, so end is checked last
			if (|din_end_pos[i]) begin
				if (open_nxt) begin
					pkt_add = pkt_add + 1'b1;
				end else begin
					err_nxt = 1'b1;
				end
				open_nxt = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			frame_open <= 1'b0;
			pkt_count  <= '0;
			frame_err  <= 1'b0;
		end else if (dout_ack) begin
			frame_open <= open_nxt;
			pkt_count  <= pkt_count + pkt_add;
			// sticky, so one fault stays visible
			frame_err  <= frame_err || err_nxt;
		end
	end

endmodule

/* verilog/e40_am_insert.sv */
// gap cycles from the break must carry all-zero flags; every word of such a cycle becomes a marker
module e40_am_insert #(
	parameter int WORDS = 2
) (
	input  logic                                 clk,
	input  logic                                 arst,
	input  e40_fmt_pkg::word_t    [WORDS-1:0]    din,
	input  logic                  [WORDS-1:0]    din_start,
	input  e40_fmt_pkg::end_pos_t [WORDS-1:0]    din_end_pos,
	input  logic                                 din_gap,
	input  logic                                 dout_ack,
	output e40_fmt_pkg::word_t    [WORDS-1:0]    dout,
	output logic                  [WORDS-1:0]    dout_start,
	output e40_fmt_pkg::end_pos_t [WORDS-1:0]    dout_end_pos,
	output logic                  [WORDS-1:0]    dout_marker
);

	e40_fmt_pkg::word_t    [WORDS-1:0] data_nxt;
	logic                  [WORDS-1:0] start_nxt;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] end_pos_nxt;
	logic                  [WORDS-1:0] marker_nxt;

	// the marker keeps the fixed upper bytes and takes the word index as its low byte
	always_comb begin
		for (int i = 0; i < WORDS; i++) begin
			if (din_gap) begin
				data_nxt[i]    = {e40_am_pkg::AM_PATTERN[63:8], e40_fmt_pkg::word_idx_t'(i)};
				start_nxt[i]   = 1'b0;
				end_pos_nxt[i] = '0;
				marker_nxt[i]  = 1'b1;
			end else begin
				data_nxt[i]    = din[i];
				start_nxt[i]   = din_start[i];
				end_pos_nxt[i] = din_end_pos[i];
				marker_nxt[i]  = 1'b0;
			end
		end
	end

	// one output stage, frozen under back-pressure like the rest of the pipe
	always_ff @(posedge clk) begin
		if (dout_ack) begin
			dout <= data_nxt;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			dout_start   <= '0;
			dout_end_pos <= '0;
			dout_marker  <= '0;
		end else if (dout_ack) begin
			dout_start   <= start_nxt;
			dout_end_pos <= end_pos_nxt;
			dout_marker  <= marker_nxt;
		end
	end

	// the break blanks a gap cycle; a flag here would be lost under the marker
	a_gap_no_flags: assert property (@(posedge clk) disable iff (arst)
		(dout_ack && din_gap) |-> (din_start == '0 && din_end_pos == '0));

endmodule

/* verilog/e40_am_sched.sv */
// period counts accepted cycles only; the actual gap runs up to three cycles past AM_GAP_CYCLES
module e40_am_sched #(
	parameter int WORDS     = 2,
	parameter int AM_PERIOD = 64
) (
	input  logic clk,
	input  logic arst,
	input  logic dout_ack,
	input  logic dout_gap,
	output logic stall_req
);

	// last count of the period and of the gap, in counter width
	localparam e40_am_pkg::am_count_t PERIOD_LAST = e40_am_pkg::am_count_t'(AM_PERIOD - 1);
	localparam e40_am_pkg::am_count_t GAP_LAST = e40_am_pkg::AM_GAP_CYCLES - 1'b1;

	e40_am_pkg::am_state_e state;
	// one counter, reused for the period and the gap length
	e40_am_pkg::am_count_t count;

	// the marker tag and the end-position map only cover these bus widths
	if (WORDS != 1 && WORDS != 2 && WORDS != 4) begin : g_words_check
		$error("e40_am_sched: WORDS must be 1, 2 or 4");
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state     <= e40_am_pkg::am_idle;
			count     <= '0;
			stall_req <= 1'b0;
		end else if (dout_ack) begin
			unique case (state)
				e40_am_pkg::am_idle: begin
					// back-pressure stretches the period in time but not in words
					if (count == PERIOD_LAST) begin
						state     <= e40_am_pkg::am_request;
						count     <= '0;
						stall_req <= 1'b1;
					end else begin
						count <= count + 1'b1;
					end
				end
				e40_am_pkg::am_request: begin
					// the break waits for a packet boundary, which may take a while
					if (dout_gap) begin
						state <= e40_am_pkg::am_gap;
						count <= 16'd1;
					end
				end
				e40_am_pkg::am_gap: begin
					if (dout_gap) begin
						if (count >= GAP_LAST) begin
							state     <= e40_am_pkg::am_idle;
							count     <= '0;
							stall_req <= 1'b0;
						end else begin
							count <= count + 1'b1;
						end
					end
				end
				default: begin
					state     <= e40_am_pkg::am_idle;
					count     <= '0;
					stall_req <= 1'b0;
				end
			endcase
		end
	end

	// the request must be held the whole time the scheduler waits for its gap
	a_req_held: assert property (@(posedge clk) disable iff (arst)
		(state == e40_am_pkg::am_request) |-> stall_req);

endmodule

/* verilog/e40_traffic_break.sv */
// gaps open only at packet boundaries; at most one start and one end per cycle, so no runts
module e40_traffic_break #(
	parameter int WORDS = 2
) (
	input  logic                                 clk,
	input  logic                                 arst,
	input  e40_fmt_pkg::word_t    [WORDS-1:0]    din,
	input  logic                  [WORDS-1:0]    din_start,
	input  e40_fmt_pkg::end_pos_t [WORDS-1:0]    din_end_pos,
	output logic                                 din_ack,
	input  logic                                 stall_req,
	output e40_fmt_pkg::word_t    [WORDS-1:0]    dout,
	output logic                  [WORDS-1:0]    dout_start,
	output e40_fmt_pkg::end_pos_t [WORDS-1:0]    dout_end_pos,
	output logic                                 dout_gap,
	input  logic                                 dout_ack,
	output logic                                 stalled
);

	// two delay stages ahead of the output, giving one cycle to decide the gap
	e40_fmt_pkg::word_t    [WORDS-1:0] data_r;
	e40_fmt_pkg::word_t    [WORDS-1:0] data_rr;
	logic                  [WORDS-1:0] start_r;
	logic                  [WORDS-1:0] start_rr;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] end_pos_r;
	e40_fmt_pkg::end_pos_t [WORDS-1:0] end_pos_rr;

	logic stall_req_r;
	logic in_packet;
	logic stalled_nxt;
	// frame state seen on the output, only read by the gap placement check
	logic out_open;

	// packet state after one cycle, given the state before it
	// with one start and one end per cycle, start plus end while open means a new packet follows
	function automatic logic pkt_open_next(input logic open, input logic any_start,
			input logic any_end);
		return (any_start && (!any_end || open)) || (open && !any_end);
	endfunction

	// the request comes from a counter, one register stage is enough
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			stall_req_r <= 1'b0;
		end else begin
			stall_req_r <= stall_req;
		end
	end

	// the input stalls whenever the downstream refuses or a gap is being emitted
	assign din_ack = dout_ack && !stalled;

	// payload moves only when a word is accepted, so a stall holds it in place
	always_ff @(posedge clk) begin
		if (din_ack) begin
			data_r  <= din;
			data_rr <= data_r;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			start_r    <= '0;
			start_rr   <= '0;
			end_pos_r  <= '0;
			end_pos_rr <= '0;
		end else if (din_ack) begin
			start_r    <= din_start;
			start_rr   <= start_r;
			end_pos_r  <= din_end_pos;
			end_pos_rr <= end_pos_r;
		end
	end

	// in_packet tracks the state after the word now in the second stage
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			in_packet <= 1'b0;
		end else if (din_ack) begin
			in_packet <= pkt_open_next(in_packet, |start_r, |end_pos_r);
		end
	end

	// once stalled, stay stalled until the request drops, in_packet is frozen meanwhile
	assign stalled_nxt = stall_req_r && (!in_packet || stalled);

	// output data has no reset; the flags below say when it is meaningful
	always_ff @(posedge clk) begin
		if (dout_ack) begin
			dout <= stalled ? '0 : data_rr;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			dout_start   <= '0;
			dout_end_pos <= '0;
			dout_gap     <= 1'b0;
			stalled      <= 1'b0;
			out_open     <= 1'b0;
		end else if (dout_ack) begin
			dout_start   <= stalled ? '0 : start_rr;
			dout_end_pos <= stalled ? '0 : end_pos_rr;
			dout_gap     <= stalled;
			stalled      <= stalled_nxt;
			out_open     <= pkt_open_next(out_open, |dout_start, |dout_end_pos);
		end
	end

	// more than one start per cycle would break the in_packet rule above
	a_one_start: assert property (@(posedge clk) disable iff (arst)
		din_ack |-> $countones(din_start) <= 1);

	// a gap reaching the output must fall between packets, never inside one
	a_gap_outside_packet: assert property (@(posedge clk) disable iff (arst)
		(dout_ack && dout_gap) |-> !out_open);

endmodule

/* verilog/e40_am_pkg.sv */
// marker scheduling types and a single fixed marker pattern; not the 40GBASE-R marker values or BIP
package e40_am_pkg;

	// scheduler states
	// am_idle counts the period, am_request holds the stall request until the gap shows up,
	// am_gap counts the gap cycles
	typedef enum logic [1:0] {
		am_idle,
		am_request,
		am_gap
	} am_state_e;

	// counter width shared by the marker period, the gap length and the packet count
	typedef logic [15:0] am_count_t;

	// marker word; the low byte is overwritten with the word index at insertion
	localparam e40_fmt_pkg::word_t AM_PATTERN = 64'h4d_a0_c3_17_6e_59_2b_00;

	// shortest gap the scheduler asks for, in accepted cycles
	localparam am_count_t AM_GAP_CYCLES = 16'd2;

endpackage

/* verilog/e40_fmt_pkg.sv */
// word format of the tx datapath; word width is fixed at 64 bits by the 8-bit end-position map
package e40_fmt_pkg;

	// bytes per bus word, one end-position bit per byte
	localparam int WORD_BYTES = 8;

	// one data word of the bus
	typedef logic [8*WORD_BYTES-1:0] word_t;

	// one-hot map of the byte that closes a packet inside a word
	// all zeros means the packet does not end in this word
	typedef logic [WORD_BYTES-1:0] end_pos_t;

	// index of a word within one bus cycle, as carried in the marker low byte
	// wide enough for any bus width this datapath is built with
	typedef logic [7:0] word_idx_t;

endpackage
